/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_xgmii_tx
FILELIST  ?= xgmii_tx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* crc32_byte_step.sv */
`timescale 1ns/10ps
`default_nettype none

module crc32_byte_step #(
    parameter logic [31:0] CRC_POLY = 32'h04C11DB7
) (
    input  logic [31:0] state_in,
    input  logic [7:0]  data,
    output logic [31:0] state_out
);

    logic [31:0] poly_rev;
    logic [31:0] crc;

    always_comb begin
        // reflected form, lsb first
        for (int i = 0; i < 32; i++) begin
            poly_rev[i] = CRC_POLY[31-i];
        end
        crc = state_in ^ {24'h000000, data};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ poly_rev) : (crc >> 1);
        end
        state_out = crc;
    end

endmodule

`default_nettype wire

/* crc32_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module crc32_chain #(
    parameter logic [31:0] CRC_POLY = 32'h04C11DB7
) (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  logic                     crc_restart,
    input  logic                     crc_update,
    input  xgmii_tx_pkg::axis_beat_t beat,
    output xgmii_tx_pkg::crc_taps_t  crc_taps
);

    logic [31:0] crc_state;

    // running crc over all completed beats of the frame
    always_ff @(posedge clk) begin
        if (reset_crc || crc_restart) begin
            crc_state <= xgmii_tx_pkg::CRC_INIT;
        end else if (crc_update) begin
            crc_state <= crc_taps[7];
        end
    end

    // byte k of the held beat advances tap k-1 into tap k
    for (genvar k = 0; k < 8; k++) begin : g_step
        logic [31:0] step_in;

        if (k == 0) begin : g_first
            assign step_in = crc_state;
        end else begin : g_next
            assign step_in = crc_taps[k-1];
        end

        crc32_byte_step #(.CRC_POLY(CRC_POLY)) u_step (
            .state_in  (step_in),
            .data      (beat.data[8*k +: 8]),
            .state_out (crc_taps[k])
        );
    end

endmodule

`default_nettype wire

/* fcs_terminator.sv */
`timescale 1ns/10ps
`default_nettype none

module fcs_terminator (
    input  xgmii_tx_pkg::axis_beat_t beat,
    input  xgmii_tx_pkg::crc_taps_t  crc_taps,
    output xgmii_tx_pkg::fcs_close_t close
);

    logic [3:0]        n;
    logic [7:0]        keep_mask;
    logic [2:0]        tap_sel;
    logic [31:0]       fcs;
    logic [127:0]      data_ext;
    logic [15:0][7:0]  lane_d;
    logic [15:0]       lane_c;

    always_comb begin
        // valid byte count and the contiguous keep it implies
        n = 4'd0;
        for (int i = 0; i < 8; i++) begin
            n = n + 4'(beat.keep[i]);
        end
        keep_mask = 8'((9'd1 << n) - 9'd1);
        tap_sel   = 3'(n - 4'd1);
        fcs       = ~crc_taps[tap_sel];
        data_ext  = {64'h0, beat.data};

        // data, fcs lsb first, terminate, then idles over 16 lanes
        for (int i = 0; i < 16; i++) begin
            if (i < int'(n)) begin
                lane_d[i] = data_ext[8*i +: 8];
                lane_c[i] = 1'b0;
            end else if (i < int'(n) + 4) begin
                lane_d[i] = 8'(fcs >> (8 * (i - int'(n))));
                lane_c[i] = 1'b0;
            end else if (i == int'(n) + 4) begin
                lane_d[i] = xgmii_tx_pkg::XGMII_TERM;
                lane_c[i] = 1'b1;
            end else begin
                lane_d[i] = xgmii_tx_pkg::XGMII_IDLE;
                lane_c[i] = 1'b1;
            end
        end

        close.word0.txd  = lane_d[7:0];
        close.word0.txc  = lane_c[7:0];
        close.word1.txd  = lane_d[15:8];
        close.word1.txc  = lane_c[15:8];
        close.two_words  = (n >= 4'd4);
        close.idle_bytes = (n >= 4'd4) ? 4'd11 - n : 4'd3 - n;
        close.bad_keep   = (n == 4'd0) || (beat.keep != keep_mask);

        // broken keep, poison both words
        if (close.bad_keep) begin
            close.word0.txd  = {8{xgmii_tx_pkg::XGMII_ERROR}};
            close.word0.txc  = 8'hff;
            close.word1.txd  = {8{xgmii_tx_pkg::XGMII_ERROR}};
            close.word1.txc  = 8'hff;
            close.two_words  = 1'b1;
            close.idle_bytes = 4'd0;
        end
    end

endmodule

`default_nettype wire

/* tb_xgmii_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_xgmii_tx;

    localparam int RESET_CYCLES = 10;
    localparam int MIN_IFG      = 12;
    localparam int FRAME_CYCLES = 16;
    localparam int NUM_FRAMES   = 14;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + 20;

    typedef logic [7:0] byte_q_t[$];
    typedef logic [8:0] lane_q_t[$];

    logic                      clk;
    logic                      reset_crc;
    xgmii_tx_pkg::axis_beat_t  s_axis;
    logic                      s_valid;
    logic                      s_ready;
    logic [7:0]                ifg_delay;
    xgmii_tx_pkg::xgmii_word_t xgmii;
    logic                      start_packet;

    logic [31:0] lfsr;
    lane_q_t     rx;
    int          value_errors;
    int          other_errors;
    int          cycles;
    logic        in_frame;
    logic        start_exp;

    xgmii_tx_top #(.MIN_IFG_BYTES(MIN_IFG)) UUT (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .s_axis       (s_axis),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .ifg_delay    (ifg_delay),
        .xgmii        (xgmii),
        .start_packet (start_packet)
    );

    bind xgmii_tx_top xgmii_tx_assert u_assert (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .s_axis       (s_axis),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .start_packet (start_packet)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the DUT did not finish", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // a transfer outside a frame opens one, and its start word follows
    always @(posedge clk) begin
        if (reset_crc) begin
            in_frame  <= 1'b0;
            start_exp <= 1'b0;
        end else begin
            start_exp <= s_valid && s_ready && !in_frame;
            if (s_valid && s_ready) begin
                in_frame <= !s_axis.last;
            end
        end
    end

    // lanes sampled mid-cycle with the control bit on top
    always @(negedge clk) begin
        for (int i = 0; i < 8; i++) begin
            rx.push_back({xgmii.txc[i], xgmii.txd[8*i +: 8]});
        end
        if (!reset_crc) begin
            check_value("start_packet", 72'(start_exp), 72'(start_packet));
            if (start_exp) begin
                check_value("xgmii lane 0", 72'({1'b1, xgmii_tx_pkg::XGMII_START}),
                            72'({xgmii.txc[0], xgmii.txd[7:0]}));
            end
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[31]};
        end
    endtask

    // ethernet fcs in reflected bitwise form
    function automatic logic [31:0] ref_fcs(input byte_q_t p);
        logic [31:0] c;
        c = 32'hffffffff;
        foreach (p[i]) begin
            c = c ^ {24'h000000, p[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic make_payload(input int len, output byte_q_t p);
        logic [7:0] b;
        p = {};
        for (int i = 0; i < len; i++) begin
            rand_byte(b);
            p.push_back(b);
        end
    endtask

    task automatic check_value(input string name, input logic [71:0] exp,
                               input logic [71:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // lanes past the last valid byte carry junk that must not leak out
    task automatic send_frame(input byte_q_t p, input logic user);
        int         nbeats;
        logic       accepted;
        logic [7:0] filler;
        nbeats = (p.size() + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            for (int i = 0; i < 8; i++) begin
                if (8 * b + i < p.size()) begin
                    s_axis.data[8*i +: 8] = p[8*b + i];
                    s_axis.keep[i] = 1'b1;
                end else begin
                    rand_byte(filler);
                    s_axis.data[8*i +: 8] = filler;
                    s_axis.keep[i] = 1'b0;
                end
            end
            s_axis.last = (b == nbeats - 1);
            s_axis.user = user && (b == nbeats - 1);
            s_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = s_ready;
                @(posedge clk);
                #1;
            end
        end
        s_valid = 1'b0;
        s_axis = '0;
    endtask

    // ready comes back once the closing words and the gap are out
    task automatic wait_ready();
        do begin
            @(negedge clk);
        end while (!s_ready);
        @(posedge clk);
        #1;
    endtask

    task automatic expect_frame(input byte_q_t p, input logic user, output lane_q_t e);
        logic [31:0] fcs;
        int          sent;
        e = {};
        e.push_back({1'b1, xgmii_tx_pkg::XGMII_START});
        for (int i = 0; i < 6; i++) begin
            e.push_back({1'b0, xgmii_tx_pkg::ETH_PRE});
        end
        e.push_back({1'b0, xgmii_tx_pkg::ETH_SFD});
        if (user) begin
            // the whole last beat becomes the error word
            sent = ((p.size() - 1) / 8) * 8;
            for (int i = 0; i < sent; i++) begin
                e.push_back({1'b0, p[i]});
            end
            for (int i = 0; i < 4; i++) begin
                e.push_back({1'b1, xgmii_tx_pkg::XGMII_ERROR});
            end
        end else begin
            fcs = ref_fcs(p);
            foreach (p[i]) begin
                e.push_back({1'b0, p[i]});
            end
            for (int i = 0; i < 4; i++) begin
                e.push_back({1'b0, fcs[8*i +: 8]});
            end
        end
        e.push_back({1'b1, xgmii_tx_pkg::XGMII_TERM});
    endtask

    // pos ends up on the lane after the terminate
    task automatic check_frame(input lane_q_t e, inout int pos);
        int s;
        int i;
        s = pos;
        while (s < rx.size() && rx[s] != {1'b1, xgmii_tx_pkg::XGMII_START}) begin
            s++;
        end
        if (s + e.size() > rx.size()) begin
            other_errors++;
            $display("frame missing or cut short after lane %0d", pos);
        end else begin
            assert (s % 8 == 0) else begin
                other_errors++;
                $display("start character outside lane 0 at lane %0d", s);
            end
            i = 0;
            while (i < e.size() - 1 && rx[s + i] === e[i]) begin
                i++;
            end
            check_value($sformatf("xgmii lane %0d", s + i), 72'(e[i]), 72'(rx[s + i]));
            pos = s + e.size();
        end
    endtask

    task automatic check_gap(input int pos, input int gap);
        int n;
        n = 0;
        while (pos + n < rx.size() && rx[pos + n] == {1'b1, xgmii_tx_pkg::XGMII_IDLE}) begin
            n++;
        end
        assert (n >= gap && n < gap + 8 && pos + n < rx.size()) else begin
            value_errors++;
            $display("CHECK FAILED t=%0t idle gap expected %0d..%0d got %0d",
                     $time, gap, gap + 7, n);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_value("xgmii", {{8{xgmii_tx_pkg::XGMII_IDLE}}, 8'hff}, xgmii);
        check_value("s_ready", 72'(1'b0), 72'(s_ready));
        check_value("start_packet", 72'(1'b0), 72'(start_packet));
        @(negedge clk);
        check_value("s_ready", 72'(1'b1), 72'(s_ready));
        @(posedge clk);
        #1;
    endtask

    task automatic test_one_frame(input int len, input logic user);
        byte_q_t p;
        lane_q_t e;
        int      pos;
        make_payload(len, p);
        rx.delete();
        send_frame(p, user);
        wait_ready();
        expect_frame(p, user, e);
        pos = 0;
        check_frame(e, pos);
    endtask

    task automatic test_gap(input logic [7:0] delay);
        byte_q_t pa;
        byte_q_t pb;
        lane_q_t ea;
        lane_q_t eb;
        int      pos;
        ifg_delay = delay;
        make_payload(21, pa);
        make_payload(18, pb);
        rx.delete();
        send_frame(pa, 1'b0);
        send_frame(pb, 1'b0);
        wait_ready();
        expect_frame(pa, 1'b0, ea);
        expect_frame(pb, 1'b0, eb);
        pos = 0;
        check_frame(ea, pos);
        check_gap(pos, (int'(delay) > MIN_IFG) ? int'(delay) : MIN_IFG);
        check_frame(eb, pos);
    endtask

    initial begin
        reset_crc    = 1'b1;
        s_valid      = 1'b0;
        s_axis       = '0;
        ifg_delay    = 8'd12;
        lfsr         = 32'h4297;
        value_errors = 0;
        other_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_crc = 1'b0;

        test_reset();
        test_one_frame(24, 1'b0);
        for (int n = 1; n <= 8; n++) begin
            test_one_frame(16 + n, 1'b0);
        end
        test_one_frame(20, 1'b1);
        test_gap(8'd5);
        test_gap(8'd20);

        $display("errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tx_beat_register.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_beat_register (
    input  logic                     clk,
    input  xgmii_tx_pkg::axis_beat_t s_axis,
    input  logic                     capture_en,
    output xgmii_tx_pkg::axis_beat_t beat
);

    xgmii_tx_pkg::axis_beat_t masked;

    // zero every byte lane that keep leaves out
    always_comb begin
        masked = s_axis;
        for (int i = 0; i < 8; i++) begin
            if (!s_axis.keep[i]) begin
                masked.data[8*i +: 8] = 8'h00;
            end
        end
    end

    // beat is held between captures, so the last beat stays put
    // while the closing words are built from it
    always_ff @(posedge clk) begin
        if (capture_en) begin
            beat <= masked;
        end
    end

endmodule

`default_nettype wire

/* xgmii_tx.f */
xgmii_tx_pkg.sv
crc32_byte_step.sv
crc32_chain.sv
tx_beat_register.sv
fcs_terminator.sv
xgmii_tx_fsm.sv
xgmii_tx_top.sv
xgmii_tx_assert.sv
tb_xgmii_tx.sv

/* xgmii_tx_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module xgmii_tx_assert (
    input logic                     clk,
    input logic                     reset_crc,
    input xgmii_tx_pkg::axis_beat_t s_axis,
    input logic                     s_valid,
    input logic                     s_ready,
    input logic                     start_packet
);

    // an offered beat stays offered until the last one transfers
    valid_held: assert property (@(posedge clk) disable iff (reset_crc)
        s_valid && !(s_ready && s_axis.last) |=> s_valid)
        else $error("s_valid dropped inside a frame");

    start_single: assert property (@(posedge clk) disable iff (reset_crc)
        start_packet |=> !start_packet)
        else $error("start_packet high for two cycles in a row");

    // nothing is taken while ready is low, so the waiting beat must hold
    stall_hold: assert property (@(posedge clk) disable iff (reset_crc)
        s_valid && !s_ready |=> s_valid && $stable(s_axis))
        else $error("beat changed while s_ready was low");

endmodule

`default_nettype wire

/* xgmii_tx_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module xgmii_tx_fsm #(
    parameter int MIN_IFG_BYTES = 12
) (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  logic                      s_valid,
    input  logic                      s_last,
    input  logic                      s_user,
    output logic                      s_ready,
    input  logic [7:0]                ifg_delay,
    input  xgmii_tx_pkg::axis_beat_t  beat,
    input  xgmii_tx_pkg::fcs_close_t  close,
    output logic                      capture_en,
    output logic                      crc_restart,
    output logic                      crc_update,
    output xgmii_tx_pkg::xgmii_word_t xgmii,
    output logic                      start_packet
);

    localparam logic [7:0] MIN_IFG = 8'(MIN_IFG_BYTES);

    xgmii_tx_pkg::tx_state_t   state, state_next;
    xgmii_tx_pkg::xgmii_word_t xgmii_next;
    logic [7:0] ifg_count, ifg_count_next;
    logic [7:0] gap_bytes;
    logic [7:0] gap_left;
    logic       ready_next;
    logic       start_next;
    logic       abort, abort_next;
    logic       close_done;
    logic       transfer;

    assign transfer   = s_valid && s_ready;
    assign capture_en = transfer;
    assign gap_bytes  = (ifg_delay > MIN_IFG) ? ifg_delay : MIN_IFG;

    // gap still uncovered after the idles behind the terminate
    always_comb begin
        if (abort) begin
            gap_left = (gap_bytes > 8'd3) ? gap_bytes - 8'd3 : 8'd0;
        end else if (gap_bytes > 8'(close.idle_bytes)) begin
            gap_left = gap_bytes - 8'(close.idle_bytes);
        end else begin
            gap_left = 8'd0;
        end
    end

    always_comb begin
        state_next     = state;
        ifg_count_next = ifg_count;
        abort_next     = abort;
        ready_next     = 1'b0;
        start_next     = 1'b0;
        close_done     = 1'b0;
        crc_restart    = 1'b0;
        crc_update     = 1'b0;
        xgmii_next.txd = {8{xgmii_tx_pkg::XGMII_IDLE}};
        xgmii_next.txc = 8'hff;

        case (state)
            xgmii_tx_pkg::IDLE: begin
                crc_restart = 1'b1;
                ready_next  = 1'b1;
                if (transfer) begin
                    // start and preamble, sfd in lane 7
                    xgmii_next.txd = {xgmii_tx_pkg::ETH_SFD, {6{xgmii_tx_pkg::ETH_PRE}},
                                      xgmii_tx_pkg::XGMII_START};
                    xgmii_next.txc = 8'h01;
                    start_next     = 1'b1;
                    state_next     = xgmii_tx_pkg::PAYLOAD;
                    if (s_last) begin
                        ready_next = 1'b0;
                        abort_next = s_user;
                        state_next = xgmii_tx_pkg::FCS_1;
                    end
                end
            end
            xgmii_tx_pkg::PAYLOAD: begin
                crc_update     = 1'b1;
                ready_next     = 1'b1;
                xgmii_next.txd = beat.data;
                xgmii_next.txc = 8'h00;
                if (transfer && s_last) begin
                    ready_next = 1'b0;
                    abort_next = s_user;
                    state_next = xgmii_tx_pkg::FCS_1;
                end
            end
            xgmii_tx_pkg::FCS_1: begin
                if (abort) begin
                    // errored frame, no fcs
                    xgmii_next.txd = {{3{xgmii_tx_pkg::XGMII_IDLE}}, xgmii_tx_pkg::XGMII_TERM,
                                      {4{xgmii_tx_pkg::XGMII_ERROR}}};
                    xgmii_next.txc = 8'hff;
                    close_done     = 1'b1;
                end else begin
                    xgmii_next = close.word0;
                    if (close.two_words) begin
                        state_next = xgmii_tx_pkg::FCS_2;
                    end else begin
                        close_done = 1'b1;
                    end
                end
            end
            xgmii_tx_pkg::FCS_2: begin
                xgmii_next = close.word1;
                close_done = 1'b1;
            end
            xgmii_tx_pkg::IFG: begin
                // one whole idle word covers eight gap bytes
                ifg_count_next = (ifg_count > 8'd8) ? ifg_count - 8'd8 : 8'd0;
                if (ifg_count_next == 8'd0) begin
                    ready_next = 1'b1;
                    state_next = xgmii_tx_pkg::IDLE;
                end
            end
            default: begin
                state_next = xgmii_tx_pkg::IDLE;
            end
        endcase

        if (close_done) begin
            abort_next     = 1'b0;
            ifg_count_next = gap_left;
            if (gap_left == 8'd0) begin
                ready_next = 1'b1;
                state_next = xgmii_tx_pkg::IDLE;
            end else begin
                state_next = xgmii_tx_pkg::IFG;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state        <= xgmii_tx_pkg::IDLE;
            ifg_count    <= 8'd0;
            abort        <= 1'b0;
            s_ready      <= 1'b0;
            start_packet <= 1'b0;
            xgmii.txd    <= {8{xgmii_tx_pkg::XGMII_IDLE}};
            xgmii.txc    <= 8'hff;
        end else begin
            state        <= state_next;
            ifg_count    <= ifg_count_next;
            abort        <= abort_next;
            s_ready      <= ready_next;
            start_packet <= start_next;
            xgmii        <= xgmii_next;
        end
    end

endmodule

`default_nettype wire

/* xgmii_tx_pkg.sv */
`default_nettype none

package xgmii_tx_pkg;

    // xgmii control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // ethernet framing bytes
    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hd5;

    localparam logic [31:0] CRC_INIT = 32'hffffffff;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } axis_beat_t;

    typedef struct packed {
        logic [63:0] txd;
        logic [7:0]  txc;
    } xgmii_word_t;

    // tap k = crc state after bytes 0..k of the held beat
    typedef logic [7:0][31:0] crc_taps_t;

    typedef struct packed {
        xgmii_word_t word0;
        xgmii_word_t word1;
        logic        two_words;
        logic [3:0]  idle_bytes;
        logic        bad_keep;
    } fcs_close_t;

    typedef enum logic [2:0] {
        IDLE,
        PAYLOAD,
        FCS_1,
        FCS_2,
        IFG
    } tx_state_t;

endpackage

`default_nettype wire

/* xgmii_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module xgmii_tx_top #(
    parameter logic [31:0] CRC_POLY      = 32'h04C11DB7,
    parameter int          MIN_IFG_BYTES = 12
) (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  xgmii_tx_pkg::axis_beat_t s_axis,
    input  logic                     s_valid,
    output logic                     s_ready,
    input  logic [7:0]               ifg_delay,
    output xgmii_tx_pkg::xgmii_word_t xgmii,
    output logic                     start_packet
);

    xgmii_tx_pkg::axis_beat_t beat;
    xgmii_tx_pkg::crc_taps_t  crc_taps;
    xgmii_tx_pkg::fcs_close_t close;
    logic                     capture_en;
    logic                     crc_restart;
    logic                     crc_update;

    tx_beat_register u_beat_register (
        .clk        (clk),
        .s_axis     (s_axis),
        .capture_en (capture_en),
        .beat       (beat)
    );

    crc32_chain #(.CRC_POLY(CRC_POLY)) u_crc_chain (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .crc_restart (crc_restart),
        .crc_update  (crc_update),
        .beat        (beat),
        .crc_taps    (crc_taps)
    );

    fcs_terminator u_fcs_terminator (
        .beat     (beat),
        .crc_taps (crc_taps),
        .close    (close)
    );

    xgmii_tx_fsm #(.MIN_IFG_BYTES(MIN_IFG_BYTES)) u_fsm (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .s_valid      (s_valid),
        .s_last       (s_axis.last),
        .s_user       (s_axis.user),
        .s_ready      (s_ready),
        .ifg_delay    (ifg_delay),
        .beat         (beat),
        .close        (close),
        .capture_en   (capture_en),
        .crc_restart  (crc_restart),
        .crc_update   (crc_update),
        .xgmii        (xgmii),
        .start_packet (start_packet)
    );

endmodule

`default_nettype wire
